// ==== design/ring_packet_pkg.sv ====
package ring_packet_pkg;

    // --------------------------------------------------------------------------
    // word size
    // --------------------------------------------------------------------------

    // one flit per packet, no segmentation
    localparam int pkt_w = 64;

    // --------------------------------------------------------------------------
    // header fields, counted from bit 0
    // --------------------------------------------------------------------------

    // channel tag written by the sender
    localparam int vc_bit = 63;

    // travel direction, set for clockwise
    localparam int dir_bit = 62;

    // hops still to go, thermometer coded
    // bit 0 set means at least one more ring hop
    localparam int hop_lsb = 48;
    localparam int hop_w   = 8;

    // bits 47:0 hold source and payload, never looked at by a node

endpackage

// ==== design/ring_router_pkg.sv ====
package ring_router_pkg;

    // ports of one node, also the index into every per-port vector
    localparam int num_ports = 3;
    localparam int port_cw   = 0;
    localparam int port_ccw  = 1;
    localparam int port_pe   = 2;

    // channels trade the external and internal roles every cycle
    localparam int num_vc  = 2;
    localparam int vc_even = 0;
    localparam int vc_odd  = 1;

    // injection hop codes accepted from the pe
    // any other code is corrupt and gets dropped at the door
    localparam logic [ring_packet_pkg::hop_w-1:0] hop_one   = 8'h01;
    localparam logic [ring_packet_pkg::hop_w-1:0] hop_two   = 8'h03;
    localparam logic [ring_packet_pkg::hop_w-1:0] hop_three = 8'h07;

endpackage

// ==== design/vc_if.sv ====
// --------------------------------------------------------------------------
// input side of one channel
// --------------------------------------------------------------------------

interface vc_in_if #(
    parameter int PKT_W     = 64,
    parameter int NUM_PORTS = 3
);
    // one strobe per input buffer, asserted for a single edge
    logic [NUM_PORTS-1:0] wen;
    // packet word for each port, already rewritten for pe
    logic [PKT_W-1:0]     wdata [NUM_PORTS];
    // buffer state back to the ready logic
    logic [NUM_PORTS-1:0] empty;

    modport ingress (output wen, output wdata, input empty);
    modport slice (input wen, input wdata, output empty);

endinterface

// --------------------------------------------------------------------------
// output side of one channel
// --------------------------------------------------------------------------

interface vc_out_if #(
    parameter int PKT_W     = 64,
    parameter int NUM_PORTS = 3
);
    // output buffer holds a packet
    logic [NUM_PORTS-1:0] full;
    // buffer contents, valid while full
    logic [PKT_W-1:0]     rdata [NUM_PORTS];
    // downstream took the packet on this edge
    logic [NUM_PORTS-1:0] ren;

    modport slice (output full, output rdata, input ren);
    modport egress (input full, input rdata, output ren);

endinterface

// ==== design/ring_ingress.sv ====
module ring_ingress (
    input  logic                              polarity,
    input  logic [ring_packet_pkg::pkt_w-1:0] cwdi,
    input  logic                              cwsi,
    output logic                              cwri,
    input  logic [ring_packet_pkg::pkt_w-1:0] ccwdi,
    input  logic                              ccwsi,
    output logic                              ccwri,
    input  logic [ring_packet_pkg::pkt_w-1:0] pedi,
    input  logic                              pesi,
    output logic                              peri,
    vc_in_if.ingress                          even_ch,
    vc_in_if.ingress                          odd_ch
);

    logic [ring_packet_pkg::pkt_w-1:0]     pe_word;
    logic                                  pe_fault;
    logic [ring_router_pkg::num_ports-1:0] ext_empty;
    logic [ring_router_pkg::num_ports-1:0] take;

    // --------------------------------------------------------------------------
    // pe injection check and rewrite
    // --------------------------------------------------------------------------

    always_comb begin
        pe_word  = pedi;
        pe_fault = 1'b0;
        case (pedi[ring_packet_pkg::hop_lsb +: ring_packet_pkg::hop_w])
            ring_router_pkg::hop_one: begin
                // neighbour in the given direction, no change
                pe_word = pedi;
            end
            ring_router_pkg::hop_two: begin
                pe_word[ring_packet_pkg::dir_bit] = 1'b0;
            end
            ring_router_pkg::hop_three: begin
                // shorter the other way round, one hop
                pe_word[ring_packet_pkg::dir_bit] = ~pedi[ring_packet_pkg::dir_bit];
                pe_word[ring_packet_pkg::hop_lsb +: ring_packet_pkg::hop_w] =
                    ring_router_pkg::hop_one;
            end
            default: begin
                pe_fault = 1'b1;
            end
        endcase
    end

    // --------------------------------------------------------------------------
    // ready and write strobes
    // --------------------------------------------------------------------------

    // even channel faces the link while polarity is high
    always_comb begin
        ext_empty = polarity ? even_ch.empty : odd_ch.empty;
        cwri      = ext_empty[ring_router_pkg::port_cw];
        ccwri     = ext_empty[ring_router_pkg::port_ccw];
        peri      = ext_empty[ring_router_pkg::port_pe];
    end

    // faulty pe word is swallowed, sender still sees a handshake
    always_comb begin
        take[ring_router_pkg::port_cw]  = cwsi & cwri;
        take[ring_router_pkg::port_ccw] = ccwsi & ccwri;
        take[ring_router_pkg::port_pe]  = pesi & peri & ~pe_fault;
        even_ch.wen = polarity ? take : '0;
        odd_ch.wen  = polarity ? '0 : take;
    end

    // same words to both channels, wen picks the one that stores
    always_comb begin
        even_ch.wdata[ring_router_pkg::port_cw]  = cwdi;
        even_ch.wdata[ring_router_pkg::port_ccw] = ccwdi;
        even_ch.wdata[ring_router_pkg::port_pe]  = pe_word;
        odd_ch.wdata[ring_router_pkg::port_cw]   = cwdi;
        odd_ch.wdata[ring_router_pkg::port_ccw]  = ccwdi;
        odd_ch.wdata[ring_router_pkg::port_pe]   = pe_word;
    end

endmodule

// ==== design/vc_slice.sv ====
module vc_slice #(
    parameter int VC_INDEX = 0
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    polarity,
    vc_in_if.slice  in_ch,
    vc_out_if.slice out_ch
);

    logic [ring_packet_pkg::pkt_w-1:0]     in_buf   [ring_router_pkg::num_ports];
    logic [ring_router_pkg::num_ports-1:0] in_full;
    logic [ring_router_pkg::num_ports-1:0] in_clr;
    logic [ring_packet_pkg::pkt_w-1:0]     out_buf  [ring_router_pkg::num_ports];
    logic [ring_router_pkg::num_ports-1:0] out_full;
    logic [ring_router_pkg::num_ports-1:0] open;
    logic                                  int_phase;
    logic                                  cw_fwd;
    logic                                  ccw_fwd;
    logic                                  pe_to_cw;
    // per output buffer, source a and source b
    logic [ring_router_pkg::num_ports-1:0] req_a;
    logic [ring_router_pkg::num_ports-1:0] req_b;
    logic [ring_router_pkg::num_ports-1:0] gnt_a;
    logic [ring_router_pkg::num_ports-1:0] gnt_b;
    logic [ring_router_pkg::num_ports-1:0] rr_ptr;
    logic [ring_packet_pkg::pkt_w-1:0]     src_a    [ring_router_pkg::num_ports];
    logic [ring_packet_pkg::pkt_w-1:0]     src_b    [ring_router_pkg::num_ports];
    logic [ring_packet_pkg::pkt_w-1:0]     out_word [ring_router_pkg::num_ports];

    // one hop used up
    function automatic logic [ring_packet_pkg::pkt_w-1:0] hop_shift(
        input logic [ring_packet_pkg::pkt_w-1:0] word
    );
        logic [ring_packet_pkg::pkt_w-1:0] res;
        res = word;
        res[ring_packet_pkg::hop_lsb +: ring_packet_pkg::hop_w] =
            word[ring_packet_pkg::hop_lsb +: ring_packet_pkg::hop_w] >> 1;
        return res;
    endfunction

    // internal while the other channel faces the link
    assign int_phase = (VC_INDEX == ring_router_pkg::vc_odd) ? polarity : ~polarity;
    assign open      = ~out_full & {ring_router_pkg::num_ports{int_phase}};

    // --------------------------------------------------------------------------
    // routing requests
    // --------------------------------------------------------------------------

    always_comb begin
        cw_fwd   = in_buf[ring_router_pkg::port_cw][ring_packet_pkg::hop_lsb];
        ccw_fwd  = in_buf[ring_router_pkg::port_ccw][ring_packet_pkg::hop_lsb];
        pe_to_cw = in_buf[ring_router_pkg::port_pe][ring_packet_pkg::dir_bit];
        // cw out: cw through traffic or pe heading cw
        req_a[ring_router_pkg::port_cw]  = in_full[ring_router_pkg::port_cw] & cw_fwd;
        req_b[ring_router_pkg::port_cw]  = in_full[ring_router_pkg::port_pe] & pe_to_cw;
        src_a[ring_router_pkg::port_cw]  = in_buf[ring_router_pkg::port_cw];
        src_b[ring_router_pkg::port_cw]  = in_buf[ring_router_pkg::port_pe];
        // ccw out: ccw through traffic or pe heading ccw
        req_a[ring_router_pkg::port_ccw] = in_full[ring_router_pkg::port_ccw] & ccw_fwd;
        req_b[ring_router_pkg::port_ccw] = in_full[ring_router_pkg::port_pe] & ~pe_to_cw;
        src_a[ring_router_pkg::port_ccw] = in_buf[ring_router_pkg::port_ccw];
        src_b[ring_router_pkg::port_ccw] = in_buf[ring_router_pkg::port_pe];
        // pe out: ring traffic that has arrived
        req_a[ring_router_pkg::port_pe]  = in_full[ring_router_pkg::port_cw] & ~cw_fwd;
        req_b[ring_router_pkg::port_pe]  = in_full[ring_router_pkg::port_ccw] & ~ccw_fwd;
        src_a[ring_router_pkg::port_pe]  = in_buf[ring_router_pkg::port_cw];
        src_b[ring_router_pkg::port_pe]  = in_buf[ring_router_pkg::port_ccw];
    end

    // --------------------------------------------------------------------------
    // two-way round robin per output buffer
    // --------------------------------------------------------------------------

    // rr_ptr low favours source a
    always_comb begin
        for (int o = 0; o < ring_router_pkg::num_ports; o++) begin
            gnt_a[o]    = open[o] & req_a[o] & (~req_b[o] | ~rr_ptr[o]);
            gnt_b[o]    = open[o] & req_b[o] & (~req_a[o] | rr_ptr[o]);
            out_word[o] = hop_shift(gnt_a[o] ? src_a[o] : src_b[o]);
        end
    end

    // each input targets one output only, so at most one grant per input
    always_comb begin
        in_clr[ring_router_pkg::port_cw]  = gnt_a[ring_router_pkg::port_cw] |
                                            gnt_a[ring_router_pkg::port_pe];
        in_clr[ring_router_pkg::port_ccw] = gnt_a[ring_router_pkg::port_ccw] |
                                            gnt_b[ring_router_pkg::port_pe];
        in_clr[ring_router_pkg::port_pe]  = gnt_b[ring_router_pkg::port_cw] |
                                            gnt_b[ring_router_pkg::port_ccw];
    end

    // --------------------------------------------------------------------------
    // buffer state
    // --------------------------------------------------------------------------

    // fill and drain never overlap, they happen in opposite phases
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_full  <= '0;
            out_full <= '0;
            rr_ptr   <= '0;
            for (int p = 0; p < ring_router_pkg::num_ports; p++) begin
                out_buf[p] <= '0;
            end
        end else begin
            in_full  <= (in_full | in_ch.wen) & ~in_clr;
            out_full <= (out_full | gnt_a | gnt_b) & ~out_ch.ren;
            for (int p = 0; p < ring_router_pkg::num_ports; p++) begin
                if (gnt_a[p] | gnt_b[p]) begin
                    out_buf[p] <= out_word[p];
                    // priority passes to the loser
                    rr_ptr[p]  <= gnt_a[p];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < ring_router_pkg::num_ports; p++) begin
            if (in_ch.wen[p]) begin
                in_buf[p] <= in_ch.wdata[p];
            end
        end
    end

    assign in_ch.empty  = ~in_full;
    assign out_ch.full  = out_full;
    assign out_ch.rdata = out_buf;

endmodule

// ==== design/ring_egress.sv ====
module ring_egress (
    input  logic                              polarity,
    vc_out_if.egress                          even_ch,
    vc_out_if.egress                          odd_ch,
    output logic [ring_packet_pkg::pkt_w-1:0] cwdo,
    output logic                              cwso,
    input  logic                              cwro,
    output logic [ring_packet_pkg::pkt_w-1:0] ccwdo,
    output logic                              ccwso,
    input  logic                              ccwro,
    output logic [ring_packet_pkg::pkt_w-1:0] pedo,
    output logic                              peso,
    input  logic                              pero
);

    logic [ring_router_pkg::num_ports-1:0] ext_full;
    logic [ring_router_pkg::num_ports-1:0] ro_vec;
    logic [ring_router_pkg::num_ports-1:0] take;

    // --------------------------------------------------------------------------
    // send side of the external channel
    // --------------------------------------------------------------------------

    // even channel faces the link while polarity is high
    always_comb begin
        ext_full = polarity ? even_ch.full : odd_ch.full;
        cwso     = ext_full[ring_router_pkg::port_cw];
        ccwso    = ext_full[ring_router_pkg::port_ccw];
        peso     = ext_full[ring_router_pkg::port_pe];
    end

    // data straight from the stored packet, holds while ro is low
    always_comb begin
        if (polarity) begin
            cwdo  = even_ch.rdata[ring_router_pkg::port_cw];
            ccwdo = even_ch.rdata[ring_router_pkg::port_ccw];
            pedo  = even_ch.rdata[ring_router_pkg::port_pe];
        end else begin
            cwdo  = odd_ch.rdata[ring_router_pkg::port_cw];
            ccwdo = odd_ch.rdata[ring_router_pkg::port_ccw];
            pedo  = odd_ch.rdata[ring_router_pkg::port_pe];
        end
    end

    // buffer frees on the so/ro edge
    always_comb begin
        ro_vec[ring_router_pkg::port_cw]  = cwro;
        ro_vec[ring_router_pkg::port_ccw] = ccwro;
        ro_vec[ring_router_pkg::port_pe]  = pero;
        take        = ext_full & ro_vec;
        even_ch.ren = polarity ? take : '0;
        odd_ch.ren  = polarity ? '0 : take;
    end

endmodule

// ==== design/gold_router.sv ====
module gold_router (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              polarity,
    // ring and pe inputs
    input  logic [ring_packet_pkg::pkt_w-1:0] cwdi,
    input  logic                              cwsi,
    output logic                              cwri,
    input  logic [ring_packet_pkg::pkt_w-1:0] ccwdi,
    input  logic                              ccwsi,
    output logic                              ccwri,
    input  logic [ring_packet_pkg::pkt_w-1:0] pedi,
    input  logic                              pesi,
    output logic                              peri,
    // ring and pe outputs
    output logic [ring_packet_pkg::pkt_w-1:0] cwdo,
    output logic                              cwso,
    input  logic                              cwro,
    output logic [ring_packet_pkg::pkt_w-1:0] ccwdo,
    output logic                              ccwso,
    input  logic                              ccwro,
    output logic [ring_packet_pkg::pkt_w-1:0] pedo,
    output logic                              peso,
    input  logic                              pero
);

    // one pair of channel bundles per virtual channel
    vc_in_if #(
        .PKT_W     (ring_packet_pkg::pkt_w),
        .NUM_PORTS (ring_router_pkg::num_ports)
    ) in_chan [ring_router_pkg::num_vc] ();

    vc_out_if #(
        .PKT_W     (ring_packet_pkg::pkt_w),
        .NUM_PORTS (ring_router_pkg::num_ports)
    ) out_chan [ring_router_pkg::num_vc] ();

    ring_ingress ring_ingress_inst (
        .polarity (polarity),
        .cwdi     (cwdi),
        .cwsi     (cwsi),
        .cwri     (cwri),
        .ccwdi    (ccwdi),
        .ccwsi    (ccwsi),
        .ccwri    (ccwri),
        .pedi     (pedi),
        .pesi     (pesi),
        .peri     (peri),
        .even_ch  (in_chan[ring_router_pkg::vc_even]),
        .odd_ch   (in_chan[ring_router_pkg::vc_odd])
    );

    // --------------------------------------------------------------------------
    // channel slices
    // --------------------------------------------------------------------------

    for (genvar g = 0; g < ring_router_pkg::num_vc; g++) begin : gen_vc
        vc_slice #(
            .VC_INDEX (g)
        ) vc_slice_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .polarity (polarity),
            .in_ch    (in_chan[g]),
            .out_ch   (out_chan[g])
        );
    end

    ring_egress ring_egress_inst (
        .polarity (polarity),
        .even_ch  (out_chan[ring_router_pkg::vc_even]),
        .odd_ch   (out_chan[ring_router_pkg::vc_odd]),
        .cwdo     (cwdo),
        .cwso     (cwso),
        .cwro     (cwro),
        .ccwdo    (ccwdo),
        .ccwso    (ccwso),
        .ccwro    (ccwro),
        .pedo     (pedo),
        .peso     (peso),
        .pero     (pero)
    );

endmodule

// ==== tb/gold_router_tb.sv ====
module gold_router_tb;

    localparam int pkts_per_port = 40;
    // worst case a packet per port every 20 cycles, plus reset and drain
    localparam int limit_cycles  = ring_router_pkg::num_ports * pkts_per_port * 20 + 200;

    logic        clk;
    logic        rst_n;
    logic        polarity;
    logic [63:0] di      [3];
    logic [2:0]  si;
    logic [2:0]  ri_vec;
    logic [63:0] do_arr  [3];
    logic [2:0]  so_vec;
    logic [2:0]  ro_vec;
    logic [2:0]  taken;
    logic        held    [3][2];
    logic [63:0] held_do [3][2];
    logic [63:0] exp_q   [3][$];
    int          sent    [3];
    int          seed;
    int          tag;
    int          idle;
    string       port_name [3] = '{"cw", "ccw", "pe"};

    gold_router gold_router_inst (
        .clk (clk), .rst_n (rst_n), .polarity (polarity),
        .cwdi (di[0]), .cwsi (si[0]), .cwri (ri_vec[0]),
        .ccwdi (di[1]), .ccwsi (si[1]), .ccwri (ri_vec[1]),
        .pedi (di[2]), .pesi (si[2]), .peri (ri_vec[2]),
        .cwdo (do_arr[0]), .cwso (so_vec[0]), .cwro (ro_vec[0]),
        .ccwdo (do_arr[1]), .ccwso (so_vec[1]), .ccwro (ro_vec[1]),
        .pedo (do_arr[2]), .peso (so_vec[2]), .pero (ro_vec[2])
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_mismatch(input string name, input logic [63:0] exp, act);
        $display("mismatch: time %0t %s expected %h actual %h", $time, name, exp, act);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // --------------------------------------------------------------------------
    // reset state
    // --------------------------------------------------------------------------

    assert property (@(posedge clk) !rst_n |-> ri_vec == 3'b111)
        else fail_mismatch("{peri,ccwri,cwri}", 3'b111, ri_vec);
    assert property (@(posedge clk) !rst_n |-> so_vec == 3'b000)
        else fail_mismatch("{peso,ccwso,cwso}", 3'b000, so_vec);
    assert property (@(posedge clk) !rst_n |-> (do_arr[0] | do_arr[1] | do_arr[2]) == 0)
        else fail_mismatch("cwdo|ccwdo|pedo", '0, do_arr[0] | do_arr[1] | do_arr[2]);

    // --------------------------------------------------------------------------
    // reference model, routes one accepted packet into an expected queue
    // --------------------------------------------------------------------------

    task automatic expect_packet(input int port, input logic [63:0] w);
        logic [7:0]  hop;
        logic [63:0] o;
        int          dest;
        hop = w[ring_packet_pkg::hop_lsb +: ring_packet_pkg::hop_w];
        o   = w;
        if (port == ring_router_pkg::port_pe) begin
            if (hop == ring_router_pkg::hop_two) begin
                o[ring_packet_pkg::dir_bit] = 1'b0;
            end else if (hop == ring_router_pkg::hop_three) begin
                o[ring_packet_pkg::dir_bit] = ~w[ring_packet_pkg::dir_bit];
                hop = ring_router_pkg::hop_one;
            end else if (hop != ring_router_pkg::hop_one) begin
                // bad code, consumed and gone
                return;
            end
            dest = o[ring_packet_pkg::dir_bit] ? ring_router_pkg::port_cw
                                               : ring_router_pkg::port_ccw;
        end else begin
            dest = hop[0] ? port : ring_router_pkg::port_pe;
        end
        o[ring_packet_pkg::hop_lsb +: ring_packet_pkg::hop_w] = hop >> 1;
        exp_q[dest].push_back(o);
    endtask

    task automatic make_packet(input int port, output logic [63:0] w);
        int          pick;
        logic [7:0]  hop;
        w       = {$random(seed), $random(seed)};
        // unique tag so any packet can be found again
        w[15:0] = tag[15:0];
        pick    = $random(seed) & 7;
        hop     = w[ring_packet_pkg::hop_lsb +: ring_packet_pkg::hop_w];
        if (port == ring_router_pkg::port_pe) begin
            case (pick)
                0, 1:    hop = ring_router_pkg::hop_one;
                2, 3:    hop = ring_router_pkg::hop_two;
                4, 5:    hop = ring_router_pkg::hop_three;
                default: hop = hop | 8'h80;
            endcase
        end else if (tag >= pkts_per_port * 3 / 2) begin
            // second half, all ring traffic drops to pe, both sources fight
            hop[0] = 1'b0;
        end
        w[ring_packet_pkg::hop_lsb +: ring_packet_pkg::hop_w] = hop;
        tag++;
    endtask

    // --------------------------------------------------------------------------
    // output monitor, called while outputs are settled
    // --------------------------------------------------------------------------

    task automatic check_outputs();
        int          hit;
        logic [63:0] head;
        for (int p = 0; p < 3; p++) begin
            // polarity picks the channel, same channel was seen two cycles back
            if (held[p][polarity]) begin
                assert (so_vec[p]) else fail_mismatch({port_name[p], "so"}, 1, so_vec[p]);
                assert (do_arr[p] == held_do[p][polarity])
                    else fail_mismatch({port_name[p], "do"}, held_do[p][polarity], do_arr[p]);
            end
            held[p][polarity]    = so_vec[p] & ~ro_vec[p];
            held_do[p][polarity] = do_arr[p];
            if (so_vec[p] && ro_vec[p]) begin
                hit  = -1;
                head = (exp_q[p].size() > 0) ? exp_q[p][0] : '0;
                for (int i = 0; i < exp_q[p].size(); i++) begin
                    if (hit < 0 && exp_q[p][i] == do_arr[p]) hit = i;
                end
                assert (hit >= 0) else fail_mismatch({port_name[p], "do"}, head, do_arr[p]);
                exp_q[p].delete(hit);
            end
        end
    endtask

    initial begin
        #(limit_cycles * 20);
        $display("timeout: expected packets still queued after %0d cycles", limit_cycles);
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        seed     = 32'h902c_297d;
        rst_n    = 1'b0;
        polarity = 1'b0;
        si       = '0;
        ro_vec   = '0;
        taken    = '0;
        tag      = 0;
        idle     = 0;
        for (int p = 0; p < 3; p++) begin
            di[p]   = '0;
            sent[p] = 0;
            held[p] = '{1'b0, 1'b0};
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (idle < 10) begin
            @(negedge clk);
            polarity = ~polarity;
            si       = si & ~taken;
            taken    = '0;
            for (int p = 0; p < 3; p++) begin
                if (!si[p] && sent[p] < pkts_per_port && ($random(seed) & 1)) begin
                    make_packet(p, di[p]);
                    si[p] = 1'b1;
                end
                ro_vec[p] = ($random(seed) & 3) != 0;
            end
            // let the combinational outputs settle before looking
            #2;
            check_outputs();
            for (int p = 0; p < 3; p++) begin
                if (si[p] && ri_vec[p]) begin
                    expect_packet(p, di[p]);
                    taken[p] = 1'b1;
                    sent[p]++;
                end
            end
            if (sent[0] + sent[1] + sent[2] == 3 * pkts_per_port && exp_q[0].size() == 0
                    && exp_q[1].size() == 0 && exp_q[2].size() == 0) begin
                idle++;
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
design/ring_packet_pkg.sv
design/ring_router_pkg.sv
design/vc_if.sv
design/ring_ingress.sv
design/vc_slice.sv
design/ring_egress.sv
design/gold_router.sv
tb/gold_router_tb.sv
